//--- capi_pkg.sv
package capi_pkg;

  // Field widths of a command line on the host interface.
  typedef logic [7:0]  cmd_tag_t;  // Command tag.
  typedef logic [12:0] cmd_code_t; // Opcode.
  typedef logic [63:0] cmd_addr_t; // Effective address.
  typedef logic [11:0] cmd_size_t; // Transfer size in bytes.

  // One command line as queued and issued, 97 bits.
  typedef struct packed {
    cmd_tag_t  tag;
    cmd_code_t command;
    cmd_addr_t address;
    cmd_size_t size;
  } command_line_t;

  // Read commands.
  localparam cmd_code_t read_cl_na  = 13'h0A00; // No allocate.
  localparam cmd_code_t read_cl_s   = 13'h0A50; // Shared.
  localparam cmd_code_t read_cl_m   = 13'h0A60; // Modified.
  localparam cmd_code_t read_cl_lck = 13'h0A6B; // Locked.
  localparam cmd_code_t read_pna    = 13'h0E00; // Partial, no allocate.

  // Write commands.
  localparam cmd_code_t write_na     = 13'h0D00;
  localparam cmd_code_t write_inj    = 13'h0D10;
  localparam cmd_code_t write_mi     = 13'h0D60;
  localparam cmd_code_t write_ms     = 13'h0D70;
  localparam cmd_code_t write_c      = 13'h0D67;
  localparam cmd_code_t write_unlock = 13'h0D6B;

  // Cache management.
  localparam cmd_code_t touch_i = 13'h0240;
  localparam cmd_code_t push_i  = 13'h0140;
  localparam cmd_code_t push_s  = 13'h0150;
  localparam cmd_code_t evict_i = 13'h1140;
  localparam cmd_code_t flush   = 13'h0100;
  localparam cmd_code_t lock    = 13'h016B;
  localparam cmd_code_t unlock  = 13'h017B;

  // Control.
  localparam cmd_code_t intreq  = 13'h0000;
  localparam cmd_code_t restart = 13'h0001; // Resume after a paged fault.

endpackage

//--- arbiter_pkg.sv
package arbiter_pkg;

  // Command sources, highest priority first.
  typedef enum logic [1:0] {
    src_wed     = 2'd0,
    src_write   = 2'd1,
    src_read    = 2'd2,
    src_restart = 2'd3
  } source_e;

  localparam int num_sources = 4;

  // One bit per source, indexed by source_e.
  typedef logic [num_sources-1:0] source_vec_t;

  // Issue credits held toward the host.
  typedef logic [7:0] credit_count_t;

  // Issue bus as seen leaving the command buffer arbiter.
  typedef struct packed {
    logic                    valid;
    capi_pkg::command_line_t command;
    source_vec_t             ready; // Copy of the current grant.
  } arbiter_out_t;

endpackage

//--- fixed_priority_arbiter.sv
`timescale 1ns/1ps

module fixed_priority_arbiter #(
  parameter int NUM_REQUESTS = 4
) (
  input  logic [NUM_REQUESTS-1:0] requests,
  output logic [NUM_REQUESTS-1:0] grants
);

  // Lowest asserted index takes the grant.
  always_comb begin
    logic taken;
    taken  = 1'b0;
    grants = '0;
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      if (requests[i] && !taken) begin
        grants[i] = 1'b1;
        taken     = 1'b1; // Blocks all lower priorities.
      end
    end
  end

endmodule

//--- command_fifo.sv
`timescale 1ns/1ps

module command_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    push,
  input  capi_pkg::command_line_t push_command,
  input  logic                    pop,
  output capi_pkg::command_line_t head_command,
  output logic                    empty,
  output logic                    full
);

  import capi_pkg::*;

  localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

  typedef logic [PTR_WIDTH-1:0] pointer_t; // Slot index, wraps at depth.
  typedef logic [PTR_WIDTH:0]   count_t;   // Occupancy, 0 to depth.

  command_line_t storage [FIFO_DEPTH];

  pointer_t write_pointer;
  pointer_t read_pointer;
  count_t   count;
  logic     do_push;
  logic     do_pop;

  assign full  = (count == count_t'(FIFO_DEPTH));
  assign empty = (count == '0);

  assign do_push = push && !full; // Pushes into a full queue are lost.
  assign do_pop  = pop && !empty;

  assign head_command = storage[read_pointer];

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      count         <= '0;
    end else begin
      if (do_push) begin
        write_pointer <= write_pointer + 1'b1;
      end
      if (do_pop) begin
        read_pointer <= read_pointer + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither.
      endcase
    end
  end

  // Storage carries payload only.
  always_ff @(posedge clock) begin
    if (do_push) begin
      storage[write_pointer] <= push_command;
    end
  end

endmodule

//--- command_credit_counter.sv
`timescale 1ns/1ps

module command_credit_counter #(
  parameter int INIT_CREDITS = 16
) (
  input  logic                       clock,
  input  logic                       rstn,
  input  logic                       spend,
  input  logic                       credit_return,
  output arbiter_pkg::credit_count_t credit_count,
  output logic                       credit_available
);

  import arbiter_pkg::*;

  localparam credit_count_t MAX_CREDITS = credit_count_t'(INIT_CREDITS);

  credit_count_t count;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      count <= MAX_CREDITS;
    end else begin
      case ({spend, credit_return})
        2'b10: begin
          if (count != '0) begin
            count <= count - 1'b1;
          end
        end
        2'b01: begin
          // Returns past the initial pool are dropped.
          if (count < MAX_CREDITS) begin
            count <= count + 1'b1;
          end
        end
        default: count <= count; // Spend and return cancel.
      endcase
    end
  end

  assign credit_count     = count;
  assign credit_available = (count != '0);

endmodule

//--- command_buffer_arbiter.sv
`timescale 1ns/1ps

module command_buffer_arbiter (
  input  logic                      clock,
  input  logic                      rstn,
  input  logic                      enabled,
  input  logic                      credit_available,
  input  arbiter_pkg::source_vec_t  not_empty,
  input  capi_pkg::command_line_t   wed_command,
  input  capi_pkg::command_line_t   write_command,
  input  capi_pkg::command_line_t   read_command,
  input  capi_pkg::command_line_t   restart_command,
  output arbiter_pkg::source_vec_t  ready,
  output arbiter_pkg::arbiter_out_t arbiter_out
);

  import capi_pkg::*;
  import arbiter_pkg::*;

  source_vec_t   requests;
  source_vec_t   grant;
  command_line_t source_commands [num_sources];
  command_line_t selected_command;
  logic          out_valid;
  command_line_t out_command;

  // No source may request without enable and a spare credit.
  assign requests = not_empty & {num_sources{enabled && credit_available}};

  fixed_priority_arbiter #(
    .NUM_REQUESTS($bits(source_vec_t))
  ) fixed_arbiter_i (
    .requests(requests),
    .grants  (grant)
  );

  assign source_commands[src_wed]     = wed_command;
  assign source_commands[src_write]   = write_command;
  assign source_commands[src_read]    = read_command;
  assign source_commands[src_restart] = restart_command;

  // One-hot grant mux, zero when idle.
  always_comb begin
    selected_command = '0;
    for (int i = 0; i < num_sources; i++) begin
      if (grant[i]) begin
        selected_command = source_commands[i];
      end
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_valid   <= 1'b0;
      out_command <= '0;
    end else begin
      out_valid   <= |grant;
      out_command <= selected_command;
    end
  end

  // Ready pops the winning queue in the same cycle it is granted.
  assign ready = grant;

  assign arbiter_out.valid   = out_valid;
  assign arbiter_out.command = out_command;
  assign arbiter_out.ready   = grant;

endmodule

//--- command_issue_top.sv
`timescale 1ns/1ps

module command_issue_top #(
  parameter int FIFO_DEPTH   = 8,
  parameter int INIT_CREDITS = 16
) (
  input  logic                          clock,
  input  logic                          rstn,
  input  logic                          enabled,
  input  arbiter_pkg::source_vec_t      push,
  input  capi_pkg::command_line_t [3:0] push_command, // Indexed by source.
  input  logic                          credit_return,
  output arbiter_pkg::source_vec_t      full,
  output logic                          command_valid,
  output capi_pkg::command_line_t       command_out,
  output arbiter_pkg::source_vec_t      ready,
  output arbiter_pkg::credit_count_t    credit_count
);

  import capi_pkg::*;
  import arbiter_pkg::*;

  command_line_t head_command [num_sources];
  source_vec_t   empty;
  source_vec_t   not_empty;
  logic          spend;
  logic          credit_available;
  arbiter_out_t  arbiter_out;

  // One queue per source, popped by its ready bit.
  for (genvar i = 0; i < num_sources; i++) begin : g_queue
    command_fifo #(
      .FIFO_DEPTH(FIFO_DEPTH)
    ) command_fifo_i (
      .clock       (clock),
      .rstn        (rstn),
      .push        (push[i]),
      .push_command(push_command[i]),
      .pop         (ready[i]),
      .head_command(head_command[i]),
      .empty       (empty[i]),
      .full        (full[i])
    );
  end

  assign not_empty = ~empty;
  assign spend     = |ready; // One credit per issued command.

  command_credit_counter #(
    .INIT_CREDITS(INIT_CREDITS)
  ) credit_counter_i (
    .clock           (clock),
    .rstn            (rstn),
    .spend           (spend),
    .credit_return   (credit_return),
    .credit_count    (credit_count),
    .credit_available(credit_available)
  );

  command_buffer_arbiter buffer_arbiter_i (
    .clock           (clock),
    .rstn            (rstn),
    .enabled         (enabled),
    .credit_available(credit_available),
    .not_empty       (not_empty),
    .wed_command     (head_command[src_wed]),
    .write_command   (head_command[src_write]),
    .read_command    (head_command[src_read]),
    .restart_command (head_command[src_restart]),
    .ready           (ready),
    .arbiter_out     (arbiter_out)
  );

  assign command_valid = arbiter_out.valid;
  assign command_out   = arbiter_out.command;

endmodule

//--- command_issue_tb.sv
`timescale 1ns/1ps

module command_issue_tb;

  import capi_pkg::*;
  import arbiter_pkg::*;

  localparam int            FIFO_DEPTH   = 8;
  localparam int            INIT_CREDITS = 16;
  localparam credit_count_t max_credits  = credit_count_t'(INIT_CREDITS);
  localparam source_vec_t   read_bit     = source_vec_t'(1) << src_read;

  logic                            clock = 1'b0;
  logic                            rstn;
  logic                            enabled;
  source_vec_t                     push;
  command_line_t [num_sources-1:0] push_command;
  logic                            credit_return;
  source_vec_t                     full;
  logic                            command_valid;
  command_line_t                   command_out;
  source_vec_t                     ready;
  credit_count_t                   credit_count;

  command_line_t model_q [num_sources][$];  // Accepted and not yet granted.
  credit_count_t model_credits   = max_credits;
  logic          pending_valid   = 1'b0;    // Granted and due on the bus next cycle.
  command_line_t pending_command = '0;
  int            source_issues [num_sources]; // Ready pulses seen per source.
  int            issued_count;
  int            accepted_count;
  int            error_count;
  int            failure_count;
  integer        seed = 32'h3ef7_cf8a;

  always #5 clock = ~clock;

  command_issue_top #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .INIT_CREDITS(INIT_CREDITS)
  ) dut_i (
    .clock        (clock),
    .rstn         (rstn),
    .enabled      (enabled),
    .push         (push),
    .push_command (push_command),
    .credit_return(credit_return),
    .full         (full),
    .command_valid(command_valid),
    .command_out  (command_out),
    .ready        (ready),
    .credit_count (credit_count)
  );

  task automatic check_command(input string name, input command_line_t expected,
                               input command_line_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t ns %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_ready(input string name, input source_vec_t expected,
                             input source_vec_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t ns %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_credits(input string name, input credit_count_t expected,
                               input credit_count_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      error_count++;
      $display("ERR %0t ns %s expected %b actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string text);
    failure_count++;
    $display("FAIL %0t ns: %s", $time, text);
  endtask

  // Typical opcode per source with random other fields.
  function automatic command_line_t random_command(input int src);
    command_line_t line;
    line.tag     = cmd_tag_t'($random(seed));
    line.address = {$random(seed), $random(seed)};
    line.size    = cmd_size_t'($random(seed));
    case (src)
      0:       line.command = read_cl_na;
      1:       line.command = write_na;
      2:       line.command = read_cl_s;
      default: line.command = restart;
    endcase
    return line;
  endfunction

  // Head of the highest priority model queue that holds anything.
  function automatic command_line_t next_expected(output int src);
    command_line_t head;
    head = '0;
    src  = -1;
    for (int i = num_sources - 1; i >= 0; i--) begin
      if (model_q[i].size() != 0) begin
        head = model_q[i][0];
        src  = i;
      end
    end
    return head;
  endfunction

  function automatic bit queues_empty();
    bit result;
    result = 1'b1;
    for (int i = 0; i < num_sources; i++) begin
      if (model_q[i].size() != 0) begin
        result = 1'b0;
      end
    end
    return result;
  endfunction

  // Compare the DUT against the model and advance the model by one edge.
  always @(posedge clock) begin : compare_outputs
    int            src;
    command_line_t expected;
    source_vec_t   expected_ready;
    source_vec_t   model_full;
    if (rstn) begin
      check_flag("command_valid", pending_valid, command_valid);
      if (pending_valid && command_valid) begin
        check_command("command_out", pending_command, command_out);
      end
      if (command_valid) begin
        issued_count++;
      end
      check_credits("credit_count", model_credits, credit_count);
      for (int i = 0; i < num_sources; i++) begin
        model_full[i] = (model_q[i].size() == FIFO_DEPTH);
      end
      check_ready("full", model_full, full);
      expected       = next_expected(src);
      expected_ready = '0;
      if (enabled && model_credits != '0 && src >= 0) begin
        expected_ready = source_vec_t'(1) << src;
      end
      check_ready("ready", expected_ready, ready);
      for (int i = 0; i < num_sources; i++) begin
        if (ready[i]) begin
          source_issues[i]++;
        end
      end
      pending_valid = 1'b0;
      if (expected_ready != '0) begin
        pending_command = expected;
        pending_valid   = 1'b1;
        void'(model_q[src].pop_front());
      end
      if (pending_valid && !credit_return) begin
        model_credits--;
      end else if (!pending_valid && credit_return && model_credits != max_credits) begin
        model_credits++;
      end
      for (int i = 0; i < num_sources; i++) begin
        if (push[i] && !model_full[i]) begin
          model_q[i].push_back(push_command[i]);
          accepted_count++;
        end
      end
    end
  end

  task automatic push_sources(input source_vec_t which, input int count);
    for (int n = 0; n < count; n++) begin
      @(negedge clock);
      push = which;
      for (int i = 0; i < num_sources; i++) begin
        push_command[i] = random_command(i);
      end
    end
    @(negedge clock);
    push = '0;
  endtask

  // Optionally hands credits back until the pool is full again.
  task automatic wait_drained(input bit give_back, input int limit);
    int cycles;
    cycles = 0;
    while ((!queues_empty() || pending_valid || command_valid ||
            (give_back && model_credits != max_credits)) && cycles < limit) begin
      @(negedge clock);
      credit_return = give_back && (model_credits != max_credits);
      cycles++;
    end
    if (!queues_empty() || pending_valid || command_valid ||
        (give_back && model_credits != max_credits)) begin
      report_failure("queued commands or credits did not settle in time");
    end
    @(negedge clock);
    credit_return = 1'b0;
  endtask

  task automatic wait_credits_zero(input int limit);
    int cycles;
    cycles = 0;
    while (credit_count != '0 && cycles < limit) begin
      @(negedge clock);
      cycles++;
    end
    if (credit_count != '0) begin
      report_failure("credit count never reached zero");
    end
  endtask

  initial begin : stimulus
    rstn          = 1'b0;
    enabled       = 1'b0;
    push          = '0;
    push_command  = '0;
    credit_return = 1'b0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;

    @(negedge clock);
    check_flag("command_valid", 1'b0, command_valid);
    check_ready("ready", '0, ready);
    check_ready("full", '0, full);
    check_credits("credit_count", max_credits, credit_count);

    // Three per queue while disabled before release.
    push_sources('1, 3);
    repeat (10) @(negedge clock);
    if (issued_count != 0) begin
      report_failure("commands issued while the stage was disabled");
    end
    enabled = 1'b1;
    wait_drained(1'b0, 100);
    if (issued_count != 4 * 3) begin
      report_failure("wrong number of commands issued after enabling");
    end

    // Four credits left against eight new commands.
    push_sources('1, 2);
    wait_credits_zero(100);
    @(negedge clock);
    issued_count = 0;
    repeat (50) @(negedge clock);
    if (issued_count != 0) begin
      report_failure("command issued with no credits left");
    end
    check_credits("credit_count", '0, credit_count);
    repeat (3) begin
      @(negedge clock);
      credit_return = 1'b1;
      @(negedge clock);
      credit_return = 1'b0;
    end
    wait_drained(1'b1, 200);

    // Overfill the read queue.
    enabled      = 1'b0;
    issued_count = 0;
    for (int i = 0; i < num_sources; i++) begin
      source_issues[i] = 0;
    end
    for (int n = 0; n < FIFO_DEPTH + 2; n++) begin
      @(negedge clock);
      check_ready("full", (n >= FIFO_DEPTH) ? read_bit : '0, full);
      push                   = read_bit;
      push_command[src_read] = random_command(src_read);
    end
    @(negedge clock);
    push = '0;
    check_ready("full", read_bit, full);
    enabled = 1'b1;
    wait_drained(1'b1, 200);
    if (source_issues[src_read] != FIFO_DEPTH || issued_count != FIFO_DEPTH) begin
      report_failure("full read queue did not issue exactly its depth");
    end

    // Random traffic, returns and enable toggles.
    issued_count   = 0;
    accepted_count = 0;
    for (int n = 0; n < 300; n++) begin
      @(negedge clock);
      for (int i = 0; i < num_sources; i++) begin
        push[i] = (($random(seed) & 3) != 0) && (model_q[i].size() < FIFO_DEPTH);
        push_command[i] = random_command(i);
      end
      credit_return = (($random(seed) & 1) != 0) && (model_credits != max_credits);
      if (($random(seed) & 15) == 0) begin
        enabled = !enabled;
      end
    end
    @(negedge clock);
    push          = '0;
    credit_return = 1'b0;
    enabled       = 1'b1;
    wait_drained(1'b1, 400);
    if (issued_count != accepted_count) begin
      report_failure("not every accepted command was issued after the drain period");
    end

    $display("Value errors: %0d, other failures: %0d", error_count, failure_count);
    if (error_count == 0 && failure_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- command_issue.f
capi_pkg.sv
arbiter_pkg.sv
fixed_priority_arbiter.sv
command_fifo.sv
command_credit_counter.sv
command_buffer_arbiter.sv
command_issue_top.sv
command_issue_tb.sv

//--- Makefile
TB_TOP  = command_issue_tb
RTL_TOP = command_issue_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f command_issue.f --top-module $(RTL_TOP)

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal -f command_issue.f \
		--top-module $(TB_TOP) -Mdir obj_dir -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
